//--- common/issue_pkg.sv
`default_nettype none

package issue_pkg;

  localparam int num_units      = 3;            // One entry per unit
  localparam int num_regs       = 64;
  localparam int num_read_ports = 2 * num_units; // Two sources per unit
  localparam int mul_stages     = 3;

  typedef logic [5:0]  tag_t;      // Physical register tag
  typedef logic [15:0] value_t;    // Operand or result
  typedef logic [3:0]  rob_idx_t;  // ROB index, also rollback count
  typedef logic [1:0]  unit_idx_t; // Unit select

  localparam tag_t zero_tag = '0;  // Always ready, never broadcast

  typedef enum logic [1:0] {
    op_add,
    op_sub,
    op_xor,
    op_mul
  } op_t;

  typedef enum logic {
    kind_alu,
    kind_mul
  } unit_kind_t;

  // Units 0 and 1 are ALUs, unit 2 is the multiplier
  localparam unit_kind_t unit_kinds [num_units] = '{kind_alu, kind_alu, kind_mul};

  // Which kind of unit executes an operation
  function automatic unit_kind_t op_kind(input op_t op);
    unit_kind_t kind;
    if (op == op_mul) begin
      kind = kind_mul;
    end else begin
      kind = kind_alu;
    end
    return kind;
  endfunction

endpackage

`default_nettype wire

//--- rs/reservation_station.sv
`timescale 1ns/1ns
`default_nettype none

module reservation_station
  import issue_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 dispatch_en,
  input  op_t                  dispatch_op,
  input  rob_idx_t             dispatch_rob_idx,
  input  tag_t                 dest_tag,
  input  tag_t                 src1_tag,
  input  logic                 src1_ready,
  input  tag_t                 src2_tag,
  input  logic                 src2_ready,
  input  logic [num_units-1:0] unit_free,
  input  logic                 cdb_valid,
  input  tag_t                 cdb_tag,
  input  logic                 rollback_en,
  input  rob_idx_t             rollback_rob_idx,
  input  rob_idx_t             rollback_count,
  output logic                 dispatch_ready,
  output logic [num_units-1:0] issue_valid,
  output op_t                  issue_op       [num_units],
  output tag_t                 issue_dest_tag [num_units],
  output tag_t                 issue_src1_tag [num_units],
  output tag_t                 issue_src2_tag [num_units]
);

  logic [num_units-1:0] busy;
  op_t                  op_q         [num_units];
  rob_idx_t             rob_idx_q    [num_units];
  tag_t                 dest_tag_q   [num_units];
  tag_t                 src1_tag_q   [num_units];
  tag_t                 src2_tag_q   [num_units];
  logic [num_units-1:0] src1_ready_q;
  logic [num_units-1:0] src2_ready_q;
  logic [num_units-1:0] src1_ok;     // Stored ready or woken now
  logic [num_units-1:0] src2_ok;
  logic [num_units-1:0] rolled;      // Inside rollback window
  logic [num_units-1:0] entry_open;  // Free or freeing this cycle
  rob_idx_t             rob_dist     [num_units];
  logic                 match_hit;
  unit_idx_t            match_idx;
  logic                 dispatch_fire;
  logic                 disp_src1_ok;
  logic                 disp_src2_ok;

  always_comb begin
    for (int i = 0; i < num_units; i++) begin
      src1_ok[i] = src1_ready_q[i] ||
                   (cdb_valid && cdb_tag != zero_tag && cdb_tag == src1_tag_q[i]);
      src2_ok[i] = src2_ready_q[i] ||
                   (cdb_valid && cdb_tag != zero_tag && cdb_tag == src2_tag_q[i]);
      issue_valid[i] = busy[i] && src1_ok[i] && src2_ok[i] && unit_free[i];
      entry_open[i]  = !busy[i] || issue_valid[i];
      rob_dist[i]    = rob_idx_q[i] - rollback_rob_idx; // Wraps modulo 16
      rolled[i]      = rollback_en && busy[i] && (rob_dist[i] <= rollback_count);
      issue_op[i]       = op_q[i];
      issue_dest_tag[i] = dest_tag_q[i];
      issue_src1_tag[i] = src1_tag_q[i];
      issue_src2_tag[i] = src2_tag_q[i];
    end
  end

  // Lowest open entry of the right kind
  always_comb begin
    match_hit = 1'b0;
    match_idx = '0;
    for (int i = 0; i < num_units; i++) begin
      if (!match_hit && entry_open[i] && unit_kinds[i] == op_kind(dispatch_op)) begin
        match_hit = 1'b1;
        match_idx = unit_idx_t'(i);
      end
    end
  end

  assign dispatch_ready = match_hit;
  assign dispatch_fire  = dispatch_en && match_hit;

  // A broadcast at the dispatch edge must not be missed
  assign disp_src1_ok = src1_ready || src1_tag == zero_tag ||
                        (cdb_valid && cdb_tag != zero_tag && cdb_tag == src1_tag);
  assign disp_src2_ok = src2_ready || src2_tag == zero_tag ||
                        (cdb_valid && cdb_tag != zero_tag && cdb_tag == src2_tag);

  always_ff @(posedge clock) begin
    for (int i = 0; i < num_units; i++) begin
      if (reset) begin
        busy[i] <= 1'b0;
      end else if (dispatch_fire && match_idx == unit_idx_t'(i)) begin
        busy[i] <= 1'b1;
      end else if (issue_valid[i] || rolled[i]) begin
        busy[i] <= 1'b0;  // Issued or rolled back
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < num_units; i++) begin
      if (dispatch_fire && match_idx == unit_idx_t'(i)) begin
        op_q[i]         <= dispatch_op;
        rob_idx_q[i]    <= dispatch_rob_idx;
        dest_tag_q[i]   <= dest_tag;
        src1_tag_q[i]   <= src1_tag;
        src2_tag_q[i]   <= src2_tag;
        src1_ready_q[i] <= disp_src1_ok;
        src2_ready_q[i] <= disp_src2_ok;
      end else begin
        src1_ready_q[i] <= src1_ok[i];  // Keep wakeups
        src2_ready_q[i] <= src2_ok[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f vlog.f --top-module issue_stage_tb -o issue_stage_sim
out=$(./obj_dir/issue_stage_sim 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
echo "Simulation did not pass"
exit 1

//--- src/alu_unit.sv
`timescale 1ns/1ns
`default_nettype none

module alu_unit
  import issue_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   issue_valid,
  input  op_t    issue_op,
  input  tag_t   issue_dest_tag,
  input  value_t operand_a,
  input  value_t operand_b,
  input  logic   grant,
  output logic   unit_free,
  output logic   result_valid,
  output tag_t   result_tag,
  output value_t result_value
);

  value_t alu_out;

  always_comb begin
    case (issue_op)
      op_add:  alu_out = operand_a + operand_b;
      op_sub:  alu_out = operand_a - operand_b;
      op_xor:  alu_out = operand_a ^ operand_b;
      default: alu_out = '0;  // Multiplies never come here
    endcase
  end

  // Free when empty or the held result leaves this cycle
  assign unit_free = !result_valid || grant;

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else if (issue_valid) begin
      result_valid <= 1'b1;
    end else if (grant) begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_valid) begin
      result_tag   <= issue_dest_tag;
      result_value <= alu_out;
    end
  end

endmodule

`default_nettype wire

//--- src/cdb_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module cdb_arbiter
  import issue_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic [num_units-1:0] result_valid,
  input  tag_t                 result_tag   [num_units],
  input  value_t               result_value [num_units],
  output logic [num_units-1:0] grant,
  output logic                 cdb_valid,
  output tag_t                 cdb_tag,
  output value_t               cdb_value
);

  unit_idx_t last_grant;  // Search starts just after this one
  unit_idx_t grant_idx;
  logic      any_grant;

  always_comb begin
    unit_idx_t cand;
    any_grant = 1'b0;
    grant_idx = last_grant;
    for (int k = 1; k <= num_units; k++) begin
      cand = unit_idx_t'((int'(last_grant) + k) % num_units);
      if (!any_grant && result_valid[cand]) begin
        any_grant = 1'b1;
        grant_idx = cand;
      end
    end
    grant = '0;
    if (any_grant) begin
      grant[grant_idx] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid  <= 1'b0;
      last_grant <= unit_idx_t'(num_units - 1);  // Unit 0 first
    end else begin
      cdb_valid <= any_grant;
      if (any_grant) begin
        last_grant <= grant_idx;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (any_grant) begin
      cdb_tag   <= result_tag[grant_idx];
      cdb_value <= result_value[grant_idx];
    end
  end

endmodule

`default_nettype wire

//--- src/issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

module issue_stage
  import issue_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     dispatch_en,
  input  op_t      dispatch_op,
  input  rob_idx_t dispatch_rob_idx,
  input  tag_t     dest_tag,
  input  tag_t     src1_tag,
  input  logic     src1_ready,
  input  tag_t     src2_tag,
  input  logic     src2_ready,
  output logic     dispatch_ready,
  input  logic     rollback_en,
  input  rob_idx_t rollback_rob_idx,
  input  rob_idx_t rollback_count,
  output logic     cdb_valid,
  output tag_t     cdb_tag,
  output value_t   cdb_value
);

  logic [num_units-1:0] unit_free;
  logic [num_units-1:0] issue_valid;
  op_t                  issue_op       [num_units];
  tag_t                 issue_dest_tag [num_units];
  tag_t                 issue_src1_tag [num_units];
  tag_t                 issue_src2_tag [num_units];
  tag_t                 read_tag       [num_read_ports];
  value_t               read_value     [num_read_ports];
  logic [num_units-1:0] result_valid;
  tag_t                 result_tag     [num_units];
  value_t               result_value   [num_units];
  logic [num_units-1:0] grant;

  // Ports 2i and 2i+1 feed unit i
  always_comb begin
    for (int i = 0; i < num_units; i++) begin
      read_tag[2*i]   = issue_src1_tag[i];
      read_tag[2*i+1] = issue_src2_tag[i];
    end
  end

  reservation_station i_reservation_station (
    .clock, .reset, .dispatch_en, .dispatch_op, .dispatch_rob_idx,
    .dest_tag, .src1_tag, .src1_ready, .src2_tag, .src2_ready,
    .unit_free, .cdb_valid, .cdb_tag,
    .rollback_en, .rollback_rob_idx, .rollback_count,
    .dispatch_ready, .issue_valid, .issue_op, .issue_dest_tag,
    .issue_src1_tag, .issue_src2_tag
  );

  phys_regfile i_phys_regfile (
    .clock, .reset,
    .write_en   (cdb_valid),  // CDB writes back
    .write_tag  (cdb_tag),
    .write_value(cdb_value),
    .read_tag, .read_value
  );

  alu_unit i_alu_0 (
    .clock, .reset,
    .issue_valid(issue_valid[0]), .issue_op(issue_op[0]), .issue_dest_tag(issue_dest_tag[0]),
    .operand_a(read_value[0]), .operand_b(read_value[1]), .grant(grant[0]),
    .unit_free(unit_free[0]), .result_valid(result_valid[0]),
    .result_tag(result_tag[0]), .result_value(result_value[0])
  );

  alu_unit i_alu_1 (
    .clock, .reset,
    .issue_valid(issue_valid[1]), .issue_op(issue_op[1]), .issue_dest_tag(issue_dest_tag[1]),
    .operand_a(read_value[2]), .operand_b(read_value[3]), .grant(grant[1]),
    .unit_free(unit_free[1]), .result_valid(result_valid[1]),
    .result_tag(result_tag[1]), .result_value(result_value[1])
  );

  mul_unit i_mul (
    .clock, .reset,
    .issue_valid(issue_valid[2]), .issue_op(issue_op[2]), .issue_dest_tag(issue_dest_tag[2]),
    .operand_a(read_value[4]), .operand_b(read_value[5]), .grant(grant[2]),
    .unit_free(unit_free[2]), .result_valid(result_valid[2]),
    .result_tag(result_tag[2]), .result_value(result_value[2])
  );

  cdb_arbiter i_cdb_arbiter (
    .clock, .reset, .result_valid, .result_tag, .result_value,
    .grant, .cdb_valid, .cdb_tag, .cdb_value
  );

endmodule

`default_nettype wire

//--- src/mul_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mul_unit
  import issue_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   issue_valid,
  input  op_t    issue_op,
  input  tag_t   issue_dest_tag,
  input  value_t operand_a,
  input  value_t operand_b,
  input  logic   grant,
  output logic   unit_free,
  output logic   result_valid,
  output tag_t   result_tag,
  output value_t result_value
);

  logic [mul_stages-1:0] stage_valid;
  tag_t                  stage_tag [mul_stages];
  logic                  advance;
  logic                  accept;
  value_t                s0_a;
  value_t                s0_b;
  value_t                s1_a;
  logic [7:0]            s1_b_hi;
  value_t                s1_partial;  // a times low byte of b
  logic [7:0]            s1_hi_prod;
  value_t                s2_product;

  // Whole pipe moves only when the last stage is empty or granted
  assign advance   = !stage_valid[mul_stages-1] || grant;
  assign unit_free = advance;
  assign accept    = issue_valid && issue_op == op_mul;

  assign s1_hi_prod = s1_a[7:0] * s1_b_hi;

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_valid <= '0;
    end else if (advance) begin
      stage_valid <= {stage_valid[mul_stages-2:0], accept};
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      stage_tag[0] <= issue_dest_tag;
      for (int s = 1; s < mul_stages; s++) begin
        stage_tag[s] <= stage_tag[s-1];
      end
      s0_a       <= operand_a;
      s0_b       <= operand_b;
      s1_a       <= s0_a;
      s1_b_hi    <= s0_b[15:8];
      s1_partial <= value_t'(s0_a * s0_b[7:0]);
      s2_product <= s1_partial + {s1_hi_prod, 8'h00};  // Low 16 bits only
    end
  end

  assign result_valid = stage_valid[mul_stages-1];
  assign result_tag   = stage_tag[mul_stages-1];
  assign result_value = s2_product;

endmodule

`default_nettype wire

//--- src/phys_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module phys_regfile
  import issue_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   write_en,
  input  tag_t   write_tag,
  input  value_t write_value,
  input  tag_t   read_tag   [num_read_ports],
  output value_t read_value [num_read_ports]
);

  value_t regs [num_regs];

  // Register p starts out holding p
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int p = 0; p < num_regs; p++) begin
        regs[p] <= value_t'(p);
      end
    end else if (write_en && write_tag != zero_tag) begin
      regs[write_tag] <= write_value;
    end
  end

  // Same-cycle CDB write is forwarded, so an op woken and issued together
  // still sees its operand
  always_comb begin
    for (int k = 0; k < num_read_ports; k++) begin
      if (read_tag[k] == zero_tag) begin
        read_value[k] = '0;
      end else if (write_en && write_tag == read_tag[k]) begin
        read_value[k] = write_value;  // Bypass
      end else begin
        read_value[k] = regs[read_tag[k]];
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/issue_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module issue_stage_tb
  import issue_pkg::*;
();

  localparam int   clk_period     = 40;
  localparam int   max_wait       = 200;         // Cycles before a wait gives up
  localparam tag_t stuck_tag      = tag_t'(63);  // No instruction produces it
  localparam int   first_init_tag = 32;          // Tags 32..62 keep their reset value
  localparam int   last_dest_tag  = 31;

  logic     clock;
  logic     reset;
  logic     dispatch_en;
  op_t      dispatch_op;
  rob_idx_t dispatch_rob_idx;
  tag_t     dest_tag;
  tag_t     src1_tag;
  logic     src1_ready;
  tag_t     src2_tag;
  logic     src2_ready;
  logic     dispatch_ready;
  logic     rollback_en;
  rob_idx_t rollback_rob_idx;
  rob_idx_t rollback_count;
  logic     cdb_valid;
  tag_t     cdb_tag;
  value_t   cdb_value;

  logic [15:0] lfsr;
  value_t      exp_val  [64];  // Expected value of every tag
  logic        pending  [64];  // Dispatched, not yet broadcast
  logic        produced [64];  // Value already in the register file
  tag_t        usable [$];     // Tags that may serve as sources
  tag_t        chain_order [$];
  tag_t        next_dest;
  rob_idx_t    rob_next;
  int          outstanding;

  issue_stage i_issue_stage (
    .clock, .reset, .dispatch_en, .dispatch_op, .dispatch_rob_idx,
    .dest_tag, .src1_tag, .src1_ready, .src2_tag, .src2_ready, .dispatch_ready,
    .rollback_en, .rollback_rob_idx, .rollback_count,
    .cdb_valid, .cdb_tag, .cdb_value
  );

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t: %s", $time, what);
    abort_run();
  endtask

  task automatic check_tag(input string name, input tag_t actual, input tag_t expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_value(input string name, input value_t actual, input value_t expected);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  function automatic int take_bits(input int count);
    int r;
    r = 0;
    for (int b = 0; b < count; b++) begin
      lfsr = lfsr_next(lfsr);
      r = (r << 1) | int'(lfsr[0]);
    end
    return r;
  endfunction

  function automatic tag_t pick_source();
    return usable[take_bits(6) % usable.size()];
  endfunction

  function automatic value_t expected_result(input op_t op, input value_t a, input value_t b);
    value_t r;
    case (op)
      op_add:  r = a + b;
      op_sub:  r = a - b;
      op_xor:  r = a ^ b;
      default: r = a * b;  // Low 16 bits of the product
    endcase
    return r;
  endfunction

  task automatic observe_cdb();
    if (cdb_valid === 1'b1) begin
      if (pending[cdb_tag] !== 1'b1) begin
        report_error($sformatf("CDB broadcast tag %0d, which is not outstanding", cdb_tag));
      end
      check_value("cdb_value", cdb_value, exp_val[cdb_tag]);
      if (chain_order.size() > 0) begin
        check_tag("cdb_tag", cdb_tag, chain_order.pop_front());  // Chains finish in order
      end
      pending[cdb_tag]  = 1'b0;
      produced[cdb_tag] = 1'b1;
      outstanding--;
    end
  endtask

  // Falling edge, outputs stable here
  task automatic tick();
    @(negedge clock);
    observe_cdb();
    dispatch_en = 1'b0;
    rollback_en = 1'b0;
  endtask

  task automatic drain(input int remaining);
    int waited;
    waited = 0;
    while (outstanding > remaining) begin
      tick();
      waited++;
      if (waited > max_wait) begin
        report_error("results did not all reach the CDB in time");
      end
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    tick();
    tick();
    reset = 1'b0;
    usable.delete();
    chain_order.delete();
    for (int t = 0; t < 64; t++) begin
      exp_val[t]  = value_t'(t);  // Register p holds p
      pending[t]  = 1'b0;
      produced[t] = (t == 0) || (t >= first_init_tag && t < 63);
      if (produced[t]) begin
        usable.push_back(tag_t'(t));
      end
    end
    next_dest = tag_t'(1);
    for (int c = 0; c < 5; c++) begin
      dispatch_op = (c % 2 == 0) ? op_add : op_mul;
      #1;
      if (dispatch_ready !== 1'b1) begin
        report_error("dispatch_ready low right after reset");
      end
      tick();
      if (cdb_valid !== 1'b0) begin
        report_error("cdb_valid rose after reset before any dispatch");
      end
    end
  endtask

  task automatic send_instr(input op_t op, input tag_t s1, input tag_t s2, input logic stuck,
                            output tag_t dest);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    if (int'(next_dest) > last_dest_tag) begin
      report_error("testbench ran out of destination tags");
    end
    dest           = next_dest;
    next_dest      = next_dest + tag_t'(1);
    exp_val[dest]  = expected_result(op, exp_val[s1], exp_val[s2]);
    pending[dest]  = 1'b1;
    produced[dest] = 1'b0;
    outstanding++;
    while (!accepted) begin
      dispatch_en      = 1'b1;
      dispatch_op      = op;
      dispatch_rob_idx = rob_next;
      dest_tag         = dest;
      src1_tag         = s1;
      src1_ready       = produced[s1];  // Late wakeups are left to the CDB
      src2_tag         = s2;
      src2_ready       = produced[s2];
      #1;
      accepted = dispatch_ready;
      tick();
      waited++;
      if (!accepted && waited > max_wait) begin
        report_error("dispatch_ready stayed low, instruction never accepted");
      end
    end
    rob_next = rob_next + rob_idx_t'(1);
    if (!stuck) begin
      usable.push_back(dest);
    end
  endtask

  task automatic random_mix(input int count);
    tag_t s1;
    tag_t dest;
    for (int k = 0; k < count; k++) begin
      s1 = pick_source();
      if (take_bits(1) == 1) begin
        s1 = usable[usable.size() - 1];  // Newest result, often not ready yet
      end
      send_instr(op_t'(take_bits(2)), s1, pick_source(), 1'b0, dest);
    end
  endtask

  task automatic dependent_chain(input int count);
    tag_t prev;
    tag_t dest;
    prev = pick_source();
    for (int k = 0; k < count; k++) begin
      send_instr(op_t'(take_bits(2)), prev, pick_source(), 1'b0, dest);
      chain_order.push_back(dest);
      prev = dest;
    end
  endtask

  // Ready sources only, so all units fight for the CDB
  task automatic cdb_burst(input int count);
    op_t  op;
    tag_t dest;
    for (int k = 0; k < count; k++) begin
      op = (take_bits(1) == 1) ? op_mul : op_t'(take_bits(2) % 3);
      send_instr(op, tag_t'(first_init_tag + take_bits(5) % 31),
                 tag_t'(first_init_tag + take_bits(5) % 31), 1'b0, dest);
    end
  endtask

  task automatic stuck_rollback();
    tag_t     dest;
    tag_t     prev;
    tag_t     stuck_dests [2];
    rob_idx_t window_start;
    window_start = rob_next;
    for (int k = 0; k < 2; k++) begin
      send_instr(k == 0 ? op_add : op_xor, stuck_tag, pick_source(), 1'b1, stuck_dests[k]);
    end
    for (int c = 0; c < 6; c++) begin
      dispatch_op = op_sub;
      #1;
      if (dispatch_ready !== 1'b0) begin
        report_error("dispatch_ready high while both ALU entries hold stuck ops");
      end
      tick();
    end
    // Mul chain outside the window, its last op still waits in its entry
    send_instr(op_mul, pick_source(), pick_source(), 1'b0, prev);
    for (int k = 0; k < 2; k++) begin
      send_instr(op_mul, prev, pick_source(), 1'b0, dest);
      prev = dest;
    end
    rollback_en      = 1'b1;
    rollback_rob_idx = window_start;
    rollback_count   = rob_idx_t'(1);
    for (int k = 0; k < 2; k++) begin
      pending[stuck_dests[k]] = 1'b0;
    end
    outstanding -= 2;
    tick();
    dispatch_op = op_add;
    #1;
    if (dispatch_ready !== 1'b1) begin
      report_error("dispatch_ready did not return after the rollback");
    end
    for (int k = 0; k < 4; k++) begin
      send_instr(op_t'(take_bits(2) % 3), pick_source(), pick_source(), 1'b0, dest);
    end
    drain(0);
  endtask

  initial begin
    reset            = 1'b1;
    dispatch_en      = 1'b0;
    dispatch_op      = op_add;
    dispatch_rob_idx = '0;
    dest_tag         = '0;
    src1_tag         = '0;
    src1_ready       = 1'b0;
    src2_tag         = '0;
    src2_ready       = 1'b0;
    rollback_en      = 1'b0;
    rollback_rob_idx = '0;
    rollback_count   = '0;
    lfsr             = 16'd64850;
    rob_next         = '0;
    outstanding      = 0;

    apply_reset();
    random_mix(28);
    drain(0);
    apply_reset();
    dependent_chain(20);
    drain(0);
    apply_reset();
    cdb_burst(24);
    drain(0);
    apply_reset();
    stuck_rollback();
    for (int c = 0; c < 20; c++) begin
      tick();  // Rolled-back tags must stay off the CDB
    end

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
common/issue_pkg.sv
rs/reservation_station.sv
src/phys_regfile.sv
src/alu_unit.sv
src/mul_unit.sv
src/cdb_arbiter.sv
src/issue_stage.sv
verification/issue_stage_tb.sv
